// ==== src/xt_bus_pkg.sv ====
package xt_bus_pkg;

	localparam int ADDR_W = 20;
	localparam int DATA_W = 8;
	localparam int SRAM_ADDR_W = 21;

	// port number as seen in an I/O cycle
	typedef struct packed {
		logic [3:0]  unused;
		logic [15:0] port;
	} io_view_t;

	// window nibble, 16 KB frame and offset in a memory cycle
	typedef struct packed {
		logic [3:0]  window;
		logic [1:0]  frame;
		logic [13:0] offset;
	} mem_view_t;

	typedef union packed {
		io_view_t  io;
		mem_view_t mem;
	} xt_addr_u;

	// space is a sideband bit, 0 for I/O and 1 for memory
	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic              space;
		xt_addr_u          paddr;
		logic [DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic              pready;
		logic              pslverr;
		logic [DATA_W-1:0] prdata;
	} apb_rsp_t;

	typedef struct packed {
		logic ems;
		logic lpt;
		logic ctl;
	} io_sel_t;

	typedef struct packed {
		logic [SRAM_ADDR_W-1:0] addr;
		logic                   we;
		logic [DATA_W-1:0]      wdata;
	} sram_req_t;

endpackage

// ==== src/xt_map_pkg.sv ====
package xt_map_pkg;

	// EMS page registers occupy four ports from here
	localparam logic [15:0] EMS_PORT_BASE = 16'h0260;

	// printer data latch
	localparam logic [15:0] LPT_PORT = 16'h0378;

	// board control register
	localparam logic [15:0] CTL_PORT = 16'h8888;

	// window nibbles, picked by ems_base_i
	// 0 gives A, 1 gives C, 2 and 3 give D
	localparam logic [3:0] EMS_WIN_A = 4'hA;
	localparam logic [3:0] EMS_WIN_C = 4'hC;
	localparam logic [3:0] EMS_WIN_D = 4'hD;

	localparam int EMS_PAGE_W = 6;

	// page register write codes
	localparam logic [7:0] EMS_DISABLE_CODE = 8'hFF;
	localparam logic [7:0] EMS_MAP_LIMIT = 8'h80;

	localparam logic [7:0] LPT_RESET = 8'hFF;
	localparam logic [7:0] CTL_RESET = 8'h00;

endpackage

// ==== src/xt_bus_control.sv ====
`timescale 1ns/10ps

module xt_bus_control
	import xt_bus_pkg::*, xt_map_pkg::*;
(
	input  logic              clock_i,
	input  logic              reset_i,
	input  apb_req_t          apb_i,
	output apb_rsp_t          apb_o,
	input  logic              ems_enable_i,
	output io_sel_t           io_sel_o,
	output logic              wr_en_o,
	output logic              mem_phase_o,
	input  logic [DATA_W-1:0] ems_rdata_i,
	input  logic [DATA_W-1:0] lpt_rdata_i,
	input  logic [DATA_W-1:0] ctl_rdata_i,
	input  logic [DATA_W-1:0] sram_rdata_i
);

	logic        access;
	logic        io_access;
	logic        mem_access;
	logic [15:0] port;
	logic        ems_hit;
	logic        lpt_hit;
	logic        ctl_hit;
	logic        wait_q;
	io_sel_t     sel;

	assign access = apb_i.psel & apb_i.penable;
	assign io_access = access & ~apb_i.space;
	assign mem_access = access & apb_i.space;

	assign port = apb_i.paddr.io.port;
	assign ems_hit = ems_enable_i && (port[15:2] == EMS_PORT_BASE[15:2]);
	assign lpt_hit = (port == LPT_PORT);
	assign ctl_hit = (port == CTL_PORT);

	// I/O cycles finish in their first access cycle
	assign sel.ems = io_access & ems_hit;
	assign sel.lpt = io_access & lpt_hit;
	assign sel.ctl = io_access & ctl_hit;

	assign io_sel_o = sel;
	assign wr_en_o = io_access & apb_i.pwrite;
	assign mem_phase_o = mem_access;

	// one wait state for memory
	always_ff @(posedge clock_i or posedge reset_i) begin
		if (reset_i) begin
			wait_q <= 1'b0;
		end else begin
			wait_q <= mem_access & ~wait_q;
		end
	end

	always_comb begin
		apb_o.pready = io_access | (mem_access & wait_q);
		apb_o.pslverr = io_access & ~(ems_hit | lpt_hit | ctl_hit);
		if (sel.ems) begin
			apb_o.prdata = ems_rdata_i;
		end else if (sel.lpt) begin
			apb_o.prdata = lpt_rdata_i;
		end else if (sel.ctl) begin
			apb_o.prdata = ctl_rdata_i;
		end else if (mem_access & ~apb_i.pwrite) begin
			apb_o.prdata = sram_rdata_i;
		end else begin
			apb_o.prdata = '0;
		end
	end

	a_setup_before_enable: assert property (@(posedge clock_i) disable iff (reset_i)
		$rose(apb_i.penable) |-> apb_i.psel && $past(apb_i.psel));

	// master holds the whole request until pready
	a_stable_while_waiting: assert property (@(posedge clock_i) disable iff (reset_i)
		access && !apb_o.pready |=> $stable(apb_i));

	a_sel_onehot: assert property (@(posedge clock_i) disable iff (reset_i)
		$onehot0({io_sel_o.ems, io_sel_o.lpt, io_sel_o.ctl}));

endmodule

// ==== src/ems_mapper.sv ====
`timescale 1ns/10ps

module ems_mapper
	import xt_bus_pkg::*, xt_map_pkg::*;
(
	input  logic                   clock_i,
	input  logic                   reset_i,
	input  logic                   sel_i,
	input  logic                   wr_en_i,
	input  xt_addr_u               addr_i,
	input  logic [DATA_W-1:0]      wdata_i,
	input  logic [1:0]             ems_base_i,
	output logic [DATA_W-1:0]      rdata_o,
	output logic [SRAM_ADDR_W-1:0] sram_addr_o
);

	logic [3:0][EMS_PAGE_W-1:0] page_q;
	logic [3:0]                 en_q;
	logic [1:0]                 reg_idx;
	logic [1:0]                 frame;
	logic [3:0]                 window;
	logic                       hit;

	assign reg_idx = addr_i.io.port[1:0];

	always_ff @(posedge clock_i or posedge reset_i) begin
		if (reset_i) begin
			page_q <= '0;
			en_q <= '0;
		end else if (sel_i && wr_en_i) begin
			if (wdata_i == EMS_DISABLE_CODE) begin
				// number is kept, only the enable drops
				en_q[reg_idx] <= 1'b0;
			end else if (wdata_i < EMS_MAP_LIMIT) begin
				page_q[reg_idx] <= wdata_i[EMS_PAGE_W-1:0];
				en_q[reg_idx] <= 1'b1;
			end
		end
	end

	always_comb begin
		if (en_q[reg_idx]) begin
			rdata_o = {{(DATA_W-EMS_PAGE_W){1'b0}}, page_q[reg_idx]};
		end else begin
			rdata_o = 8'hFF;
		end
	end

	// window base from the config pins
	always_comb begin
		case (ems_base_i)
			2'd0: window = EMS_WIN_A;
			2'd1: window = EMS_WIN_C;
			default: window = EMS_WIN_D;
		endcase
	end

	assign frame = addr_i.mem.frame;
	assign hit = (addr_i.mem.window == window) && en_q[frame];

	// mapped pages land in the upper megabyte
	always_comb begin
		if (hit) begin
			sram_addr_o = {1'b1, page_q[frame], addr_i.mem.offset};
		end else begin
			sram_addr_o = {1'b0, addr_i};
		end
	end

	a_write_needs_sel: assert property (@(posedge clock_i) disable iff (reset_i)
		!(sel_i && wr_en_i) |=> $stable(page_q) && $stable(en_q));

endmodule

// ==== src/io_latches.sv ====
`timescale 1ns/10ps

module io_latches
	import xt_bus_pkg::*, xt_map_pkg::*;
(
	input  logic              clock_i,
	input  logic              reset_i,
	input  logic              sel_lpt_i,
	input  logic              sel_ctl_i,
	input  logic              wr_en_i,
	input  logic [DATA_W-1:0] wdata_i,
	output logic [DATA_W-1:0] lpt_rdata_o,
	output logic [DATA_W-1:0] ctl_rdata_o,
	output logic [DATA_W-1:0] lpt_data_o,
	output logic [DATA_W-1:0] ctl_o
);

	logic [DATA_W-1:0] lpt_q;
	logic [DATA_W-1:0] ctl_q;

	always_ff @(posedge clock_i or posedge reset_i) begin
		if (reset_i) begin
			lpt_q <= LPT_RESET;
			ctl_q <= CTL_RESET;
		end else begin
			if (sel_lpt_i && wr_en_i) begin
				lpt_q <= wdata_i;
			end
			if (sel_ctl_i && wr_en_i) begin
				ctl_q <= wdata_i;
			end
		end
	end

	// pins and read-back show the same latch
	assign lpt_data_o = lpt_q;
	assign ctl_o = ctl_q;
	assign lpt_rdata_o = lpt_q;
	assign ctl_rdata_o = ctl_q;

endmodule

// ==== src/sram_port.sv ====
`timescale 1ns/10ps

module sram_port
	import xt_bus_pkg::*;
(
	input  logic                   clock_i,
	input  logic                   reset_i,
	input  logic                   mem_phase_i,
	input  apb_req_t               apb_i,
	input  logic [SRAM_ADDR_W-1:0] addr_i,
	output sram_req_t              sram_o,
	input  logic [DATA_W-1:0]      sram_rdata_i,
	output logic [DATA_W-1:0]      rdata_o
);

	logic              second_q;
	logic              first_cycle;
	logic [DATA_W-1:0] rdata_q;

	// toggles through the two access cycles
	always_ff @(posedge clock_i or posedge reset_i) begin
		if (reset_i) begin
			second_q <= 1'b0;
		end else begin
			second_q <= mem_phase_i & ~second_q;
		end
	end

	assign first_cycle = mem_phase_i & ~second_q;

	always_ff @(posedge clock_i) begin
		if (first_cycle) begin
			rdata_q <= sram_rdata_i;
		end
	end

	assign sram_o.addr = addr_i;
	assign sram_o.wdata = apb_i.pwdata;
	assign sram_o.we = first_cycle & apb_i.pwrite;
	assign rdata_o = rdata_q;

	a_we_single_cycle: assert property (@(posedge clock_i) disable iff (reset_i)
		sram_o.we |=> !sram_o.we);

endmodule

// ==== src/xt_chipset_top.sv ====
`timescale 1ns/10ps

module xt_chipset_top
	import xt_bus_pkg::*;
(
	input  logic              clock,
	input  logic              reset,
	input  apb_req_t          apb_i,
	output apb_rsp_t          apb_o,
	input  logic              ems_enable_i,
	input  logic [1:0]        ems_base_i,
	output sram_req_t         sram_o,
	input  logic [DATA_W-1:0] sram_rdata_i,
	output logic [DATA_W-1:0] lpt_data_o,
	output logic [DATA_W-1:0] ctl_o
);

	io_sel_t                io_sel;
	logic                   wr_en;
	logic                   mem_phase;
	logic [DATA_W-1:0]      ems_rdata;
	logic [DATA_W-1:0]      lpt_rdata;
	logic [DATA_W-1:0]      ctl_rdata;
	logic [DATA_W-1:0]      mem_rdata;
	logic [SRAM_ADDR_W-1:0] sram_addr;

	xt_bus_control u_bus_control (
		.clock_i      (clock),
		.reset_i      (reset),
		.apb_i        (apb_i),
		.apb_o        (apb_o),
		.ems_enable_i (ems_enable_i),
		.io_sel_o     (io_sel),
		.wr_en_o      (wr_en),
		.mem_phase_o  (mem_phase),
		.ems_rdata_i  (ems_rdata),
		.lpt_rdata_i  (lpt_rdata),
		.ctl_rdata_i  (ctl_rdata),
		.sram_rdata_i (mem_rdata)
	);

	ems_mapper u_ems_mapper (
		.clock_i     (clock),
		.reset_i     (reset),
		.sel_i       (io_sel.ems),
		.wr_en_i     (wr_en),
		.addr_i      (apb_i.paddr),
		.wdata_i     (apb_i.pwdata),
		.ems_base_i  (ems_base_i),
		.rdata_o     (ems_rdata),
		.sram_addr_o (sram_addr)
	);

	io_latches u_io_latches (
		.clock_i     (clock),
		.reset_i     (reset),
		.sel_lpt_i   (io_sel.lpt),
		.sel_ctl_i   (io_sel.ctl),
		.wr_en_i     (wr_en),
		.wdata_i     (apb_i.pwdata),
		.lpt_rdata_o (lpt_rdata),
		.ctl_rdata_o (ctl_rdata),
		.lpt_data_o  (lpt_data_o),
		.ctl_o       (ctl_o)
	);

	sram_port u_sram_port (
		.clock_i      (clock),
		.reset_i      (reset),
		.mem_phase_i  (mem_phase),
		.apb_i        (apb_i),
		.addr_i       (sram_addr),
		.sram_o       (sram_o),
		.sram_rdata_i (sram_rdata_i),
		.rdata_o      (mem_rdata)
	);

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clock_o,
	output logic reset_o
);

	// 40 ns period
	initial begin
		clock_o = 1'b0;
		forever #20 clock_o = ~clock_o;
	end

	// held over two rising edges
	initial begin
		reset_o = 1'b1;
		repeat (2) @(posedge clock_o);
		reset_o <= 1'b0;
	end

endmodule

// ==== sim/tb_xt_chipset.sv ====
`timescale 1ns/10ps

module tb_xt_chipset
	import xt_bus_pkg::*;
();

	// 4 + 40 + 68 + 4 * (4 + 30) + 20 transfers
	localparam int NUM_TRANSFERS = 268;
	localparam int TIMEOUT_CYCLES = 2 * NUM_TRANSFERS * 3;
	localparam int SRAM_WORDS = 1 << SRAM_ADDR_W;

	logic              clock;
	logic              reset;
	apb_req_t          apb_req;
	apb_rsp_t          apb_rsp;
	logic              ems_enable;
	logic [1:0]        ems_base;
	sram_req_t         sram_req;
	logic [DATA_W-1:0] sram_rdata;
	logic [DATA_W-1:0] lpt_data;
	logic [DATA_W-1:0] ctl;

	logic [DATA_W-1:0] sram_mem [0:SRAM_WORDS-1];
	logic [DATA_W-1:0] shadow_mem [0:SRAM_WORDS-1];

	// reference copies of the page registers and latches
	logic [3:0][5:0] page_m;
	logic [3:0]      en_m;
	logic [7:0]      lpt_m;
	logic [7:0]      ctl_m;

	logic [31:0] rng_state = 32'h449a_c814;
	int          cycle_count = 0;
	int          check_count = 0;
	int          error_count = 0;
	int          test_errors = 0;

	tb_clock_gen u_clock_gen (
		.clock_o (clock),
		.reset_o (reset)
	);

	xt_chipset_top DUT (
		.clock        (clock),
		.reset        (reset),
		.apb_i        (apb_req),
		.apb_o        (apb_rsp),
		.ems_enable_i (ems_enable),
		.ems_base_i   (ems_base),
		.sram_o       (sram_req),
		.sram_rdata_i (sram_rdata),
		.lpt_data_o   (lpt_data),
		.ctl_o        (ctl)
	);

	// asynchronous-read SRAM
	assign sram_rdata = sram_mem[sram_req.addr];

	always @(posedge clock) begin
		if (sram_req.we) begin
			sram_mem[sram_req.addr] <= sram_req.wdata;
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Run timed out after %0d cycles", cycle_count);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		// fold high bits down, the low LCG bits repeat quickly
		return rng_state ^ (rng_state >> 15);
	endfunction

	function automatic logic [7:0] fill_byte(input logic [20:0] addr);
		return addr[7:0] ^ addr[15:8] ^ {3'b000, addr[20:16]} ^ 8'h5A;
	endfunction

	function automatic void ems_model_write(input logic [1:0] idx, input logic [7:0] data);
		if (data == 8'hFF) begin
			en_m[idx] = 1'b0;
		end else if (data < 8'h80) begin
			page_m[idx] = data[5:0];
			en_m[idx] = 1'b1;
		end
	endfunction

	function automatic logic [7:0] ems_model_read(input logic [1:0] idx);
		return en_m[idx] ? {2'b00, page_m[idx]} : 8'hFF;
	endfunction

	function automatic logic [20:0] model_translate(input logic [19:0] addr);
		logic [3:0] win;
		logic [1:0] frame;
		case (ems_base)
			2'd0: win = 4'hA;
			2'd1: win = 4'hC;
			default: win = 4'hD;
		endcase
		frame = addr[15:14];
		if (addr[19:16] == win && en_m[frame]) begin
			return {1'b1, page_m[frame], addr[13:0]};
		end
		return {1'b0, addr};
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("Mismatch at %0t: %s expected %0h, actual %0h", $time, name, expected,
				actual);
		end
	endtask

	task automatic report_test(input int num, input string name);
		$display("test %0d %s finished, %0d errors", num, name, error_count - test_errors);
		test_errors = error_count;
	endtask

	// one APB transfer, returns after the completion edge at the next falling edge
	task automatic apb_transfer(input logic space, input logic write, input logic [19:0] addr,
			input logic [7:0] wdata, output logic [7:0] rdata, output logic err,
			output int cycles);
		apb_req_t    next_req;
		logic [20:0] exp_addr;
		logic        done;
		int          we_count;
		next_req = '0;
		next_req.psel = 1'b1;
		next_req.pwrite = write;
		next_req.space = space;
		next_req.paddr = addr;
		next_req.pwdata = wdata;
		exp_addr = model_translate(addr);
		done = 1'b0;
		we_count = 0;
		rdata = '0;
		err = 1'b0;
		@(posedge clock);
		apb_req <= next_req;
		cycles = 1;
		@(posedge clock);
		apb_req.penable <= 1'b1;
		cycles++;
		while (!done) begin
			@(negedge clock);
			if (sram_req.we) begin
				we_count++;
				compare_value("sram_o.addr", 32'(exp_addr), 32'(sram_req.addr));
				compare_value("sram_o.wdata", 32'(wdata), 32'(sram_req.wdata));
			end
			if (apb_rsp.pready) begin
				rdata = apb_rsp.prdata;
				err = apb_rsp.pslverr;
				done = 1'b1;
			end else begin
				@(posedge clock);
				cycles++;
			end
		end
		@(posedge clock);
		apb_req.psel <= 1'b0;
		apb_req.penable <= 1'b0;
		@(negedge clock);
		compare_value("sram_o.we pulses", 32'(space & write), 32'(we_count));
	endtask

	task automatic check_reset_values();
		logic [7:0] rdata;
		logic       err;
		int         cycles;
		compare_value("lpt_data_o", 32'hFF, 32'(lpt_data));
		compare_value("ctl_o", 32'h00, 32'(ctl));
		for (int i = 0; i < 4; i++) begin
			apb_transfer(1'b0, 1'b0, 20'h00260 + 20'(i), 8'h00, rdata, err, cycles);
			compare_value("ems prdata", 32'hFF, 32'(rdata));
			compare_value("ems pslverr", 32'h0, 32'(err));
		end
		report_test(1, "reset values");
	endtask

	task automatic latch_traffic();
		logic [31:0] r;
		logic [15:0] port;
		logic [7:0]  rdata;
		logic        err;
		int          cycles;
		for (int n = 0; n < 40; n++) begin
			r = next_random();
			port = r[16] ? 16'h8888 : 16'h0378;
			apb_transfer(1'b0, r[17], {r[23:20], port}, r[31:24], rdata, err, cycles);
			if (r[17]) begin
				if (r[16]) begin
					ctl_m = r[31:24];
				end else begin
					lpt_m = r[31:24];
				end
			end else begin
				compare_value("latch prdata", 32'(r[16] ? ctl_m : lpt_m), 32'(rdata));
			end
			compare_value("lpt_data_o", 32'(lpt_m), 32'(lpt_data));
			compare_value("ctl_o", 32'(ctl_m), 32'(ctl));
			compare_value("latch pslverr", 32'h0, 32'(err));
			compare_value("latch cycles", 32'd2, 32'(cycles));
		end
		report_test(2, "printer and control latches");
	endtask

	task automatic ems_register_traffic();
		logic [31:0] r;
		logic [1:0]  idx;
		logic [7:0]  data;
		logic [7:0]  rdata;
		logic        err;
		int          cycles;
		for (int n = 0; n < 68; n++) begin
			if (n == 60) begin
				@(posedge clock);
				ems_enable <= 1'b0;
			end
			r = next_random();
			idx = r[1:0];
			case (r[3:2])
				2'd0: data = 8'hFF;
				2'd1, 2'd2: data = {1'b0, r[14:8]};
				default: data = {1'b1, r[14:8]};
			endcase
			apb_transfer(1'b0, r[4], {r[23:20], 14'h0098, idx}, data, rdata, err, cycles);
			if (ems_enable) begin
				if (r[4]) begin
					ems_model_write(idx, data);
				end else begin
					compare_value("ems prdata", 32'(ems_model_read(idx)), 32'(rdata));
				end
				compare_value("ems pslverr", 32'h0, 32'(err));
			end else begin
				// mapper switched off, ports look undecoded
				compare_value("ems pslverr", 32'h1, 32'(err));
				if (!r[4]) begin
					compare_value("ems prdata", 32'h0, 32'(rdata));
				end
			end
			compare_value("ems cycles", 32'd2, 32'(cycles));
		end
		@(posedge clock);
		ems_enable <= 1'b1;
		report_test(3, "EMS page registers");
	endtask

	task automatic memory_traffic();
		logic [31:0] r;
		logic [3:0]  nib;
		logic [19:0] addr;
		logic [20:0] maddr;
		logic [7:0]  data;
		logic [7:0]  rdata;
		logic        err;
		int          cycles;
		for (int b = 0; b < 4; b++) begin
			@(posedge clock);
			ems_base <= 2'(b);
			for (int i = 0; i < 4; i++) begin
				r = next_random();
				data = (r[1:0] == 2'd0) ? 8'hFF : {1'b0, r[14:8]};
				apb_transfer(1'b0, 1'b1, {4'h0, 14'h0098, 2'(i)}, data, rdata, err, cycles);
				ems_model_write(2'(i), data);
			end
			for (int n = 0; n < 30; n++) begin
				r = next_random();
				case (r[1:0])
					2'd0: nib = 4'hA;
					2'd1: nib = 4'hC;
					2'd2: nib = 4'hD;
					default: nib = r[7:4];
				endcase
				// a few offsets so reads hit earlier writes
				addr = {nib, r[9:8], r[13:12], 8'h00, r[27:24]};
				maddr = model_translate(addr);
				apb_transfer(1'b1, r[2], addr, r[23:16], rdata, err, cycles);
				if (r[2]) begin
					shadow_mem[maddr] = r[23:16];
				end else begin
					compare_value("mem prdata", 32'(shadow_mem[maddr]), 32'(rdata));
				end
				compare_value("mem pslverr", 32'h0, 32'(err));
				compare_value("mem cycles", 32'd3, 32'(cycles));
			end
		end
		report_test(4, "memory and EMS translation");
	endtask

	task automatic undecoded_reads();
		logic [31:0] r;
		logic [15:0] port;
		logic [7:0]  rdata;
		logic        err;
		int          cycles;
		for (int n = 0; n < 20; n++) begin
			r = next_random();
			port = r[31:16];
			if (port[15:2] == 14'h0098 || port == 16'h0378 || port == 16'h8888) begin
				port = port ^ 16'h1000;
			end
			apb_transfer(1'b0, 1'b0, {r[3:0], port}, 8'h00, rdata, err, cycles);
			compare_value("undecoded prdata", 32'h0, 32'(rdata));
			compare_value("undecoded pslverr", 32'h1, 32'(err));
			compare_value("undecoded cycles", 32'd2, 32'(cycles));
		end
		report_test(5, "undecoded ports");
	endtask

	initial begin
		apb_req = '0;
		ems_enable = 1'b1;
		ems_base = 2'd0;
		page_m = '0;
		en_m = '0;
		lpt_m = 8'hFF;
		ctl_m = 8'h00;
		for (int i = 0; i < SRAM_WORDS; i++) begin
			sram_mem[i] = fill_byte(21'(i));
			shadow_mem[i] = fill_byte(21'(i));
		end
		wait (reset == 1'b0);
		@(negedge clock);
		check_reset_values();
		latch_traffic();
		ems_register_traffic();
		memory_traffic();
		undecoded_reads();
		$display("tests: 5, checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
src/xt_bus_pkg.sv
src/xt_map_pkg.sv
src/xt_bus_control.sv
src/ems_mapper.sv
src/io_latches.sv
src/sram_port.sv
src/xt_chipset_top.sv
sim/tb_clock_gen.sv
sim/tb_xt_chipset.sv

// ==== run.sh ====
#!/bin/sh
# build and run the chipset testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_xt_chipset -o tb_xt_chipset
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_xt_chipset > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
